/* logic/rioPkg.sv */
package rioPkg;

	////////////////////
	// link constants
	////////////////////

	// k28.2 marks the start of a packet in the low byte
	localparam logic [7:0] K_START = 8'h5C;

	// crc-32, msb first, no final inversion
	localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;
	localparam logic [31:0] CRC_POLY = 32'h04C1_1DB7;

	// header fields
	// length in bits 31:20, address in bits 19:8
	localparam int LEN_W = 12;
	localparam int ADDR_W = 12;

	// receive buffer size in words
	localparam int BUF_DEPTH = 512;
	localparam int BUF_AW = $clog2(BUF_DEPTH);

	// cycles to wait for our own packet to come back around the ring
	localparam logic [15:0] REMOTE_TIMEOUT = 16'd3000;

	////////////////////
	// word types
	////////////////////

	// one word as it comes off the link
	typedef struct packed {
		logic [31:0] data;
		logic        isK;
	} rioWord_t;

	// one forwarded word with packet boundary marks
	typedef struct packed {
		logic [31:0] data;
		logic        sop;
		logic        eop;
	} txWord_t;

	// verdict for one received packet
	typedef struct packed {
		logic             valid;
		logic             crcOk;
		logic             isOwn;
		logic [LEN_W-1:0] len;
	} checkResult_t;

	// remote mode states
	typedef enum logic [1:0] {
		IDLE,
		WAIT_OWN,
		DONE,
		TIMEOUT
	} remoteState_t;

endpackage

/* logic/packetCrc.sv */
module packetCrc
	import rioPkg::*;
(
	input  logic        RioRxClock,
	input  logic        crcInit_i,
	input  logic        crcEn_i,
	input  logic [31:0] data_i,
	output logic [31:0] crc_o
);

	// advance the crc over one 32 bit word, msb first
	function automatic logic [31:0] crcStep(input logic [31:0] crcIn, input logic [31:0] data);
		logic [31:0] c;
		c = crcIn;
		for (int i = 31; i >= 0; i--)
		begin
			// feedback is the top crc bit against the data bit
			if (c[31] ^ data[i])
				c = {c[30:0], 1'b0} ^ CRC_POLY;
			else
				c = {c[30:0], 1'b0};
		end
		return c;
	endfunction

	// the init word is folded in from the start value
	always_ff @(posedge RioRxClock)
	begin
		if (crcInit_i)
			crc_o <= crcStep(CRC_INIT, data_i);
		else if (crcEn_i)
			crc_o <= crcStep(crc_o, data_i);
	end

endmodule

/* logic/rxPacketBuffer.sv */
module rxPacketBuffer
	import rioPkg::*;
(
	input  logic        RioRxClock,
	input  logic        rstN_i,
	input  logic [31:0] wrData_i,
	input  logic        write_i,
	input  logic        read_i,
	output logic [31:0] rdData_o,
	output logic        empty_o
);

	logic [31:0]     mem [BUF_DEPTH];
	// pointers carry one extra wrap bit
	logic [BUF_AW:0] wrPtr;
	logic [BUF_AW:0] rdPtr;
	logic            full;

	assign empty_o = (wrPtr == rdPtr);
	// full when the wrap bits differ and the addresses match
	assign full = (wrPtr[BUF_AW] != rdPtr[BUF_AW]) &&
		(wrPtr[BUF_AW-1:0] == rdPtr[BUF_AW-1:0]);

	// storage
	always_ff @(posedge RioRxClock)
	begin
		if (write_i)
			mem[wrPtr[BUF_AW-1:0]] <= wrData_i;
	end

	// registered read, data shows up the cycle after read_i
	always_ff @(posedge RioRxClock)
	begin
		if (read_i)
			rdData_o <= mem[rdPtr[BUF_AW-1:0]];
	end

	always_ff @(posedge RioRxClock)
	begin
		if (!rstN_i)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (write_i)
				wrPtr <= wrPtr + 1'b1;
			if (read_i)
				rdPtr <= rdPtr + 1'b1;
		end
	end

	// no back-pressure on the link, so overflow means a lost word
	assert property (@(posedge RioRxClock) disable iff (!rstN_i) write_i |-> !full);
	// flush only ever reads words that were written
	assert property (@(posedge RioRxClock) disable iff (!rstN_i) read_i |-> !empty_o);

endmodule

/* logic/packetFramer.sv */
module packetFramer
	import rioPkg::*;
(
	input  logic              RioRxClock,
	input  logic              rstN_i,
	input  rioWord_t          rxWord_i,
	input  logic [ADDR_W-1:0] myStopAddress_i,
	input  logic [31:0]       crcValue_i,
	output logic [31:0]       bufData_o,
	output logic              bufWrite_o,
	output logic              crcInit_o,
	output logic              crcEn_o,
	output checkResult_t      checkResult_o
);

	rioWord_t          inReg;
	logic              isHdr;
	logic              isPayload;
	logic              isCrcWord;
	// words left in the packet, payload plus the crc word
	logic [LEN_W:0]    count;
	logic [ADDR_W-1:0] pktAddr;
	logic [LEN_W-1:0]  pktLen;

	// one register stage on the link input
	always_ff @(posedge RioRxClock)
	begin
		if (!rstN_i)
			inReg <= '0;
		else
			inReg <= rxWord_i;
	end

	// header is a k character carrying the start byte
	assign isHdr = inReg.isK && (inReg.data[7:0] == K_START);
	// count above one means payload, exactly one means the crc word
	assign isPayload = (count[LEN_W:1] != '0);
	assign isCrcWord = (count == (LEN_W+1)'(1));

	// header and payload go to the buffer and the crc
	assign bufData_o = inReg.data;
	assign bufWrite_o = isHdr || isPayload;
	assign crcInit_o = isHdr;
	assign crcEn_o = isHdr || isPayload;

	// load length plus one on the header, then count down to zero
	always_ff @(posedge RioRxClock)
	begin
		if (!rstN_i)
			count <= '0;
		else if (isHdr)
			count <= {1'b0, inReg.data[31:20]} + 1'b1;
		else if (count != '0)
			count <= count - 1'b1;
	end

	// keep address and length of the packet in flight
	always_ff @(posedge RioRxClock)
	begin
		if (isHdr)
		begin
			pktAddr <= inReg.data[19:8];
			pktLen <= inReg.data[31:20];
		end
	end

	// verdict one cycle after the crc word, crc is settled by then
	always_ff @(posedge RioRxClock)
	begin
		if (!rstN_i)
			checkResult_o <= '0;
		else
		begin
			checkResult_o.valid <= isCrcWord;
			checkResult_o.crcOk <= (crcValue_i == inReg.data);
			checkResult_o.isOwn <= (pktAddr == myStopAddress_i);
			checkResult_o.len <= pktLen;
		end
	end

	// a new header must not cut into a packet still being received
	assert property (@(posedge RioRxClock) disable iff (!rstN_i)
		isHdr |-> (count == '0));

endmodule

/* logic/packetForwarder.sv */
module packetForwarder
	import rioPkg::*;
(
	input  logic         RioRxClock,
	input  logic         rstN_i,
	input  checkResult_t checkResult_i,
	input  logic [31:0]  bufData_i,
	input  logic         crcClear_i,
	output logic         bufRead_o,
	output txWord_t      txWord_o,
	output logic         txValid_o,
	output logic         packetDropped_o,
	output logic [31:0]  crcErrorCount_o
);

	checkResult_t   pend;
	checkResult_t   nextVerdict;
	logic [LEN_W:0] flushCnt;
	logic           startFlush;
	// verdict of the packet now being flushed
	logic           curFwd;
	logic           firstWord;
	logic           rdSop;
	logic           rdEop;

	////////////////////
	// flush control
	////////////////////

	// a queued verdict goes ahead of a fresh one
	assign nextVerdict = pend.valid ? pend : checkResult_i;
	// start on the last read of the previous flush so packets stay contiguous
	assign startFlush = nextVerdict.valid && (flushCnt[LEN_W:1] == '0);
	assign bufRead_o = (flushCnt != '0);

	// header plus payload words are read back
	always_ff @(posedge RioRxClock)
	begin
		if (!rstN_i)
		begin
			flushCnt <= '0;
			curFwd <= 1'b0;
			firstWord <= 1'b0;
		end
		else if (startFlush)
		begin
			flushCnt <= {1'b0, nextVerdict.len} + 1'b1;
			// forward only good packets that are not ours
			curFwd <= nextVerdict.crcOk && !nextVerdict.isOwn;
			firstWord <= 1'b1;
		end
		else
		begin
			if (flushCnt != '0)
				flushCnt <= flushCnt - 1'b1;
			if (bufRead_o)
				firstWord <= 1'b0;
		end
	end

	// single verdict queue for a packet finishing during a flush
	always_ff @(posedge RioRxClock)
	begin
		if (!rstN_i)
			pend <= '0;
		else if (pend.valid)
		begin
			if (startFlush)
				pend <= checkResult_i;
		end
		else if (checkResult_i.valid && !startFlush)
			pend <= checkResult_i;
	end

	////////////////////
	// output marking
	////////////////////

	// flags line up with the registered buffer data
	always_ff @(posedge RioRxClock)
	begin
		if (!rstN_i)
		begin
			txValid_o <= 1'b0;
			rdSop <= 1'b0;
			rdEop <= 1'b0;
		end
		else
		begin
			txValid_o <= bufRead_o && curFwd;
			rdSop <= bufRead_o && firstWord;
			rdEop <= (flushCnt == (LEN_W+1)'(1));
		end
	end

	assign txWord_o = '{data: bufData_i, sop: rdSop, eop: rdEop};

	// drop pulse and error count, clear wins over a new error
	always_ff @(posedge RioRxClock)
	begin
		if (!rstN_i)
		begin
			packetDropped_o <= 1'b0;
			crcErrorCount_o <= '0;
		end
		else
		begin
			packetDropped_o <= checkResult_i.valid && !checkResult_i.crcOk;
			if (crcClear_i)
				crcErrorCount_o <= '0;
			else if (checkResult_i.valid && !checkResult_i.crcOk)
				crcErrorCount_o <= crcErrorCount_o + 32'd1;
		end
	end

	// link spacing leaves room for one queued verdict at most
	assert property (@(posedge RioRxClock) disable iff (!rstN_i)
		(pend.valid && !startFlush) |-> !checkResult_i.valid);

endmodule

/* logic/remoteModeFsm.sv */
module remoteModeFsm
	import rioPkg::*;
(
	input  logic         RioRxClock,
	input  logic         rstN_i,
	input  logic         trigger_i,
	input  checkResult_t checkResult_i,
	output logic         remoteModeDone_o,
	output logic         remoteTimeout_o
);

	remoteState_t state;
	logic [15:0]  waitCnt;
	logic         ownBack;

	// our packet made it round the ring intact
	assign ownBack = checkResult_i.valid && checkResult_i.isOwn && checkResult_i.crcOk;

	////////////////////
	// state register
	////////////////////

	always_ff @(posedge RioRxClock)
	begin
		if (!rstN_i)
		begin
			state <= IDLE;
			waitCnt <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					waitCnt <= '0;
					if (trigger_i)
						state <= WAIT_OWN;
				end
				WAIT_OWN:
				begin
					// a bad own packet keeps us waiting
					if (ownBack)
						state <= DONE;
					else if (waitCnt == REMOTE_TIMEOUT - 16'd1)
						state <= TIMEOUT;
					else
						waitCnt <= waitCnt + 16'd1;
				end
				// both end states last one cycle
				DONE:
					state <= IDLE;
				TIMEOUT:
					state <= IDLE;
				default:
					state <= IDLE;
			endcase
		end
	end

	// pulses straight from the state
	assign remoteModeDone_o = (state == DONE);
	assign remoteTimeout_o = (state == TIMEOUT);

	// a wait ends one way or the other, never both
	assert property (@(posedge RioRxClock) disable iff (!rstN_i)
		!(remoteModeDone_o && remoteTimeout_o));

endmodule

/* logic/rioPacketProcessor.sv */
module rioPacketProcessor
	import rioPkg::*;
(
	input  logic              RioRxClock,
	input  logic              rstN_i,
	input  rioWord_t          rxWord_i,
	input  logic [ADDR_W-1:0] myStopAddress_i,
	input  logic              trigger_i,
	input  logic              crcClear_i,
	output txWord_t           txWord_o,
	output logic              txValid_o,
	output logic              packetDropped_o,
	output logic [31:0]       crcErrorCount_o,
	output logic              remoteModeDone_o,
	output logic              remoteTimeout_o
);

	// framer to buffer and crc
	logic [31:0]  bufData;
	logic         bufWrite;
	logic         crcInit;
	logic         crcEn;
	logic [31:0]  crcValue;
	// verdict fans out to forwarder and remote fsm
	checkResult_t checkResult;
	// buffer read side
	logic         bufRead;
	logic [31:0]  rdData;

	////////////////////
	// receive side
	////////////////////

	packetFramer packetFramer_i (
		.RioRxClock      (RioRxClock),
		.rstN_i          (rstN_i),
		.rxWord_i        (rxWord_i),
		.myStopAddress_i (myStopAddress_i),
		.crcValue_i      (crcValue),
		.bufData_o       (bufData),
		.bufWrite_o      (bufWrite),
		.crcInit_o       (crcInit),
		.crcEn_o         (crcEn),
		.checkResult_o   (checkResult)
	);

	packetCrc packetCrc_i (
		.RioRxClock (RioRxClock),
		.crcInit_i  (crcInit),
		.crcEn_i    (crcEn),
		.data_i     (bufData),
		.crc_o      (crcValue)
	);

	// empty flag only feeds the buffer's own checks
	rxPacketBuffer rxPacketBuffer_i (
		.RioRxClock (RioRxClock),
		.rstN_i     (rstN_i),
		.wrData_i   (bufData),
		.write_i    (bufWrite),
		.read_i     (bufRead),
		.rdData_o   (rdData),
		.empty_o    ()
	);

	////////////////////
	// forward side
	////////////////////

	packetForwarder packetForwarder_i (
		.RioRxClock      (RioRxClock),
		.rstN_i          (rstN_i),
		.checkResult_i   (checkResult),
		.bufData_i       (rdData),
		.crcClear_i      (crcClear_i),
		.bufRead_o       (bufRead),
		.txWord_o        (txWord_o),
		.txValid_o       (txValid_o),
		.packetDropped_o (packetDropped_o),
		.crcErrorCount_o (crcErrorCount_o)
	);

	remoteModeFsm remoteModeFsm_i (
		.RioRxClock       (RioRxClock),
		.rstN_i           (rstN_i),
		.trigger_i        (trigger_i),
		.checkResult_i    (checkResult),
		.remoteModeDone_o (remoteModeDone_o),
		.remoteTimeout_o  (remoteTimeout_o)
	);

endmodule

/* verif/tbPacketTasks.svh */
`ifndef TB_PACKET_TASKS_SVH
`define TB_PACKET_TASKS_SVH

////////////////////
// stimulus source
////////////////////

// galois lfsr, right shifting, x^32 + x^22 + x^2 + x + 1
function automatic logic nextLfsrBit();
	logic outBit;
	outBit = lfsrState[0];
	lfsrState = lfsrState >> 1;
	if (outBit)
		lfsrState = lfsrState ^ LFSR_TAPS;
	return outBit;
endfunction

// gather n bits, one lfsr step per bit
function automatic logic [31:0] randBits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++)
		r = {r[30:0], nextLfsrBit()};
	return r;
endfunction

////////////////////
// reference crc
////////////////////

// crc-32 over one word, msb first, poly xor masked by the feedback bit
function automatic logic [31:0] crcFold(input logic [31:0] crc, input logic [31:0] word);
	logic [31:0] acc;
	logic        fb;
	acc = crc;
	for (int i = 31; i >= 0; i--)
	begin
		fb = acc[31] ^ word[i];
		acc = (acc << 1) ^ (CRC_POLY & {32{fb}});
	end
	return acc;
endfunction

////////////////////
// link driving
////////////////////

// one word on the link per rising edge
task automatic sendWord(input logic [31:0] data, input logic isK);
	@(posedge RioRxClock);
	rxWord_i <= '{data: data, isK: isK};
endtask

// header, payload, crc word, then one idle word as the gap
// good packets for another node are queued as expected output
task automatic sendPacket(input logic [11:0] addr, input int len, input logic corrupt);
	logic [31:0] hdr;
	logic [31:0] crc;
	logic [31:0] payload;
	logic        fwd;
	hdr = {len[11:0], addr, K_START};
	fwd = !corrupt && (addr != myStopAddress_i);
	crc = crcFold(CRC_INIT, hdr);
	if (fwd)
		expQ.push_back('{data: hdr, sop: 1'b1, eop: (len == 0)});
	sendWord(hdr, 1'b1);
	for (int i = 0; i < len; i++)
	begin
		payload = randBits(32);
		crc = crcFold(crc, payload);
		if (fwd)
			expQ.push_back('{data: payload, sop: 1'b0, eop: (i == len - 1)});
		sendWord(payload, 1'b0);
	end
	// a single flipped bit is enough to fail the check
	if (corrupt)
		crc = crc ^ (32'd1 << randBits(5));
	sendWord(crc, 1'b0);
	sendWord(32'd0, 1'b0);
endtask

`endif

/* verif/tbRioPacketProcessor.sv */
module tbRioPacketProcessor
	import rioPkg::*;
;

	localparam int TIMEOUT_CYCLES = int'(REMOTE_TIMEOUT) + 2000;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
	localparam logic [11:0] OWN_ADDR = 12'h2A7;

	logic        RioRxClock;
	logic        rstN_i;
	rioWord_t    rxWord_i;
	logic [11:0] myStopAddress_i;
	logic        trigger_i;
	logic        crcClear_i;
	txWord_t     txWord_o;
	logic        txValid_o;
	logic        packetDropped_o;
	logic [31:0] crcErrorCount_o;
	logic        remoteModeDone_o;
	logic        remoteTimeout_o;

	logic [31:0] lfsrState = 32'h9ccd_f793;
	// words still owed by the DUT in arrival order
	txWord_t     expQ[$];
	txWord_t     expHead;
	logic        expAvail;
	int          errors;
	int          testsRun;
	int          testsBad;
	int          cycleCount;
	// pulse tallies seen on the outputs
	int          dropSeen;
	int          doneSeen;
	int          timeoutSeen;

	`include "tbPacketTasks.svh"

	rioPacketProcessor rioPacketProcessor_i (
		.RioRxClock       (RioRxClock),
		.rstN_i           (rstN_i),
		.rxWord_i         (rxWord_i),
		.myStopAddress_i  (myStopAddress_i),
		.trigger_i        (trigger_i),
		.crcClear_i       (crcClear_i),
		.txWord_o         (txWord_o),
		.txValid_o        (txValid_o),
		.packetDropped_o  (packetDropped_o),
		.crcErrorCount_o  (crcErrorCount_o),
		.remoteModeDone_o (remoteModeDone_o),
		.remoteTimeout_o  (remoteTimeout_o)
	);

	initial
	begin
		RioRxClock = 1'b0;
		forever #5 RioRxClock = ~RioRxClock;
	end

	////////////////////
	// output monitors
	////////////////////

	// queue head settles mid cycle for the next rising edge
	always @(negedge RioRxClock)
	begin
		expAvail = (expQ.size() != 0);
		expHead = expAvail ? expQ[0] : '0;
	end

	always @(posedge RioRxClock)
	begin
		if (rstN_i)
		begin
			if (txValid_o && expQ.size() != 0)
				void'(expQ.pop_front());
			dropSeen += int'(packetDropped_o);
			doneSeen += int'(remoteModeDone_o);
			timeoutSeen += int'(remoteTimeout_o);
		end
	end

	assert property (@(posedge RioRxClock) disable iff (!rstN_i) txValid_o |-> expAvail)
	else
	begin
		$display("output word arrived when none was expected");
		errors++;
	end

	// data, sop and eop all at once
	assert property (@(posedge RioRxClock) disable iff (!rstN_i)
		(txValid_o && expAvail) |-> (txWord_o == expHead))
	else
	begin
		$display("mismatch txWord_o got %h expected %h", $sampled(txWord_o), $sampled(expHead));
		errors++;
	end

	assert property (@(posedge RioRxClock) disable iff (!rstN_i)
		packetDropped_o |=> !packetDropped_o)
	else
	begin
		$display("drop pulse lasted longer than one cycle");
		errors++;
	end

	assert property (@(posedge RioRxClock) disable iff (!rstN_i)
		remoteModeDone_o |-> !remoteTimeout_o)
	else
	begin
		$display("remote done and timeout were high together");
		errors++;
	end

	assert property (@(posedge RioRxClock) disable iff (!rstN_i)
		(remoteModeDone_o || remoteTimeout_o) |=> !(remoteModeDone_o || remoteTimeout_o))
	else
	begin
		$display("remote mode pulse lasted longer than one cycle");
		errors++;
	end

	////////////////////
	// check helpers
	////////////////////

	task automatic compareValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected)
		else
		begin
			$display("mismatch %s got %h expected %h", name, got, expected);
			errors++;
		end
	endtask

	task automatic confirm(input logic cond, input string what);
		assert (cond)
		else
		begin
			$display("%s", what);
			errors++;
		end
	endtask

	// unknown or stale outputs fail here
	task automatic checkResetState();
		confirm(!txValid_o && !packetDropped_o && !remoteModeDone_o && !remoteTimeout_o,
			"control outputs not low after reset");
		compareValue("crcErrorCount_o", crcErrorCount_o, 32'd0);
	endtask

	task automatic finishTest(input string name, input int errBefore);
		testsRun++;
		if (errors == errBefore)
			$display("test %s: ok", name);
		else
		begin
			testsBad++;
			$display("test %s: %0d errors", name, errors - errBefore);
		end
	endtask

	task automatic pulseTrigger();
		@(posedge RioRxClock);
		trigger_i <= 1'b1;
		@(posedge RioRxClock);
		trigger_i <= 1'b0;
	endtask

	task automatic clearErrorCount();
		@(posedge RioRxClock);
		crcClear_i <= 1'b1;
		@(posedge RioRxClock);
		crcClear_i <= 1'b0;
	endtask

	////////////////////
	// test sequence
	////////////////////

	initial
	begin
		int errBefore;
		int dropBefore;
		int doneBefore;
		int timeoutBefore;
		int waited;
		rstN_i = 1'b0;
		rxWord_i = '0;
		myStopAddress_i = OWN_ADDR;
		trigger_i = 1'b0;
		crcClear_i = 1'b0;
		repeat (3) @(posedge RioRxClock);
		rstN_i <= 1'b1;

		// outputs start unknown until the first reset edge
		errBefore = errors;
		@(negedge RioRxClock);
		checkResetState();
		finishTest("reset values", errBefore);

		// good packet for another node
		errBefore = errors;
		dropBefore = dropSeen;
		sendPacket(12'h155, 5, 1'b0);
		while (expQ.size() != 0)
			@(posedge RioRxClock);
		confirm(dropSeen == dropBefore, "good packet raised a drop pulse");
		finishTest("forward good packet", errBefore);

		// one flipped crc bit and a counter clear
		errBefore = errors;
		dropBefore = dropSeen;
		sendPacket(12'h0C3, 4, 1'b1);
		while (dropSeen == dropBefore)
			@(posedge RioRxClock);
		@(negedge RioRxClock);
		compareValue("crcErrorCount_o", crcErrorCount_o, 32'd1);
		clearErrorCount();
		@(negedge RioRxClock);
		compareValue("crcErrorCount_o", crcErrorCount_o, 32'd0);
		confirm(dropSeen == dropBefore + 1, "crc error gave more than one drop pulse");
		finishTest("crc error and clear", errBefore);

		// back to back packets with mixed verdicts and one idle word between them
		errBefore = errors;
		dropBefore = dropSeen;
		sendPacket(12'h201, 6, 1'b0);
		sendPacket(12'h202, 2, 1'b1);
		sendPacket(12'h203, 5, 1'b0);
		sendPacket(12'h204, 3, 1'b0);
		sendPacket(12'h205, 4, 1'b1);
		while (expQ.size() != 0 || dropSeen < dropBefore + 2)
			@(posedge RioRxClock);
		@(negedge RioRxClock);
		compareValue("crcErrorCount_o", crcErrorCount_o, 32'd2);
		finishTest("back to back packets", errBefore);

		// own packet returns after a corrupted copy
		errBefore = errors;
		dropBefore = dropSeen;
		doneBefore = doneSeen;
		timeoutBefore = timeoutSeen;
		pulseTrigger();
		sendPacket(OWN_ADDR, 3, 1'b1);
		while (dropSeen == dropBefore)
			@(posedge RioRxClock);
		confirm(doneSeen == doneBefore, "remote mode finished on a corrupted own packet");
		sendPacket(OWN_ADDR, 4, 1'b0);
		while (doneSeen == doneBefore)
			@(posedge RioRxClock);
		confirm(timeoutSeen == timeoutBefore, "remote timeout fired before own packet");
		finishTest("remote mode done", errBefore);

		// no own packet at all
		errBefore = errors;
		doneBefore = doneSeen;
		timeoutBefore = timeoutSeen;
		waited = 0;
		pulseTrigger();
		while (timeoutSeen == timeoutBefore)
		begin
			@(negedge RioRxClock);
			waited++;
		end
		// the wait starts on the trigger edge and the pulse is tallied one edge after it
		confirm(waited == int'(REMOTE_TIMEOUT) + 2,
			"remote timeout did not come after the full wait");
		confirm(doneSeen == doneBefore, "remote done pulsed without own packet");
		@(posedge RioRxClock);
		rstN_i <= 1'b0;
		repeat (3) @(posedge RioRxClock);
		rstN_i <= 1'b1;
		@(negedge RioRxClock);
		checkResetState();
		finishTest("remote timeout and reset", errBefore);

		$display("summary: %0d run, %0d ok, %0d bad", testsRun, testsRun - testsBad, testsBad);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// whole run fits in one remote wait plus margin for the packet tests
	initial
	begin
		cycleCount = 0;
		while (cycleCount < TIMEOUT_CYCLES)
		begin
			@(posedge RioRxClock);
			cycleCount++;
		end
		$display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("tests failed");
		$finish;
	end

endmodule

/* flist.f */
+incdir+verif
logic/rioPkg.sv
logic/packetCrc.sv
logic/rxPacketBuffer.sv
logic/packetFramer.sv
logic/packetForwarder.sv
logic/remoteModeFsm.sv
logic/rioPacketProcessor.sv
verif/tbRioPacketProcessor.sv

/* Bender.yml */
package:
  name: rioPacketProcessor

sources:
  - files:
      - logic/rioPkg.sv
      - logic/packetCrc.sv
      - logic/rxPacketBuffer.sv
      - logic/packetFramer.sv
      - logic/packetForwarder.sv
      - logic/remoteModeFsm.sv
      - logic/rioPacketProcessor.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tbRioPacketProcessor.sv
